/* source/ctrlPkg.sv */
// Shared types and codes for the multicycle RISC-V control unit
// Mux and ALU encodings must match the external datapath
// Opcode set limited to load, store, R, I, JAL and BEQ
`default_nettype none

package ctrlPkg;

    typedef logic [6:0]  opcode_t;   // Major opcode, instr[6:0]
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  aluOp_t;
    typedef logic [31:0] addr_t;     // Byte address, also the PC
    typedef logic [33:0] busWord_t;  // {cmd[1:0], flags[1:0], payload[29:0]}
    typedef logic [2:0]  credit_t;   // Up to 7 outstanding credits

    // Major opcodes
    localparam opcode_t OpLoad   = 7'b0000011;
    localparam opcode_t OpStore  = 7'b0100011;
    localparam opcode_t OpRType  = 7'b0110011;
    localparam opcode_t OpIType  = 7'b0010011;
    localparam opcode_t OpJal    = 7'b1101111;
    localparam opcode_t OpBranch = 7'b1100011;

    localparam aluOp_t AluAdd   = 3'b000;
    localparam aluOp_t AluSub   = 3'b001;
    localparam aluOp_t AluRType = 3'b010; // Datapath resolves op from funct3

    // ALU A input select
    localparam logic [1:0] SrcAPc    = 2'b00;
    localparam logic [1:0] SrcAOldPc = 2'b01;
    localparam logic [1:0] SrcAReg   = 2'b10;

    // ALU B input select
    localparam logic [1:0] SrcBReg  = 2'b00;
    localparam logic [1:0] SrcBImm  = 2'b01;
    localparam logic [1:0] SrcBFour = 2'b10;

    // Result bus select
    localparam logic [1:0] ResAluOut    = 2'b00;
    localparam logic [1:0] ResData      = 2'b01;
    localparam logic [1:0] ResAluResult = 2'b10;

    localparam logic [1:0] CmdSetAddr   = 2'b10;
    localparam logic [1:0] CmdRead      = 2'b00;
    localparam logic [1:0] CmdFlagsNone = 2'b00; // No increment, no write

    typedef enum logic [2:0] {
        ClsLoad,
        ClsStore,
        ClsRType,
        ClsIType,
        ClsJal,
        ClsBranch,
        ClsIllegal
    } instrClass_e;

    typedef enum logic [3:0] {
        SFetch,
        SDecode,
        SMemAddr,
        SMemRead,
        SMemWb,
        SMemWrite,
        SExecR,
        SExecI,
        SAluWb,
        SJal,
        SBeq,
        SError
    } seqState_e;

    // Fields of the instruction register seen by the controller
    typedef struct packed {
        opcode_t op;
        funct3_t funct3;
        logic    funct7b5;
    } instrFields_t;

    typedef struct packed {
        logic       pcWrite;
        logic       adrSrc;     // 0 PC, 1 ALUOut
        logic       memWrite;
        logic       irWrite;
        logic       regWrite;
        logic [1:0] resultSrc;
        aluOp_t     aluControl;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] immSrc;     // Always I-format here
    } ctrlWord_t;

    typedef struct packed {
        logic     valid;
        busWord_t word;
    } busCmd_t;

endpackage

`default_nettype wire

/* source/opcodeDecoder.sv */
// Pure combinational opcode classifier, zero latency
// Unknown opcodes map to ClsIllegal, no partial decode
// ALU op is only meaningful in the execute states
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder
(
    input  wire ctrlPkg::instrFields_t instr,
    output ctrlPkg::instrClass_e       instrClass,
    output ctrlPkg::aluOp_t            execAluOp
);
    import ctrlPkg::*;

    logic isSub; // R-type subtract request

    // funct3 000 with funct7b5 set means sub
    assign isSub = (instr.funct3 == 3'b000) && instr.funct7b5;

    // Opcode to class
    always_comb
    begin
        case (instr.op)
            OpLoad:
            begin
                instrClass = ClsLoad;
            end
            OpStore:
            begin
                instrClass = ClsStore;
            end
            OpRType:
            begin
                instrClass = ClsRType;
            end
            OpIType:
            begin
                instrClass = ClsIType;
            end
            OpJal:
            begin
                instrClass = ClsJal;
            end
            OpBranch:
            begin
                instrClass = ClsBranch;
            end
            default:
            begin
                instrClass = ClsIllegal; // Sequencer traps on this
            end
        endcase
    end

    // ALU operation used by SExecR and SExecI
    always_comb
    begin
        case (instrClass)
            ClsIType:
            begin
                execAluOp = aluOp_t'(instr.funct3); // funct3 passes straight through
            end
            ClsRType:
            begin
                execAluOp = isSub ? AluSub : AluRType;
            end
            default:
            begin
                execAluOp = AluAdd;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/fetchPort.sv */
// Instruction fetch over the command bus, set-address then read
// A command goes out only while a credit is held
// Bus must answer each read exactly once, never in the issue cycle
// CmdCredits valid from 1 to 7
`timescale 1ns/1ps
`default_nettype none

module fetchPort
#(
    parameter int unsigned CmdCredits = 2
)
(
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           fetchStart,
    input  wire ctrlPkg::addr_t pc,
    input  wire logic           creditReturn,
    input  wire logic           rspValid,
    output ctrlPkg::busCmd_t    cmd,
    output logic                fetchDone
);
    import ctrlPkg::*;

    typedef enum logic [1:0] {
        Idle,
        Addr,
        Read,
        Wait
    } fetchState_e;

    fetchState_e state;
    fetchState_e nextState;
    credit_t     credits;
    logic        hasCredit;
    logic        sendCmd;   // One credit consumed this cycle

    assign hasCredit = (credits != '0);
    assign sendCmd   = hasCredit && ((state == Addr) || (state == Read));

    // Command word depends only on the phase
    always_comb
    begin
        cmd.valid = sendCmd;
        if (state == Read)
        begin
            cmd.word = {CmdRead, 32'b0};          // Payload ignored by the bus
        end
        else
        begin
            cmd.word = {CmdSetAddr, CmdFlagsNone, pc[29:0]};
        end
    end

    assign fetchDone = (state == Wait) && rspValid;

    always_comb
    begin
        nextState = state;
        case (state)
            Idle:
            begin
                if (fetchStart)
                begin
                    nextState = Addr;
                end
            end
            Addr:
            begin
                if (hasCredit)
                begin
                    nextState = Read;
                end
            end
            Read:
            begin
                if (hasCredit)
                begin
                    nextState = Wait;
                end
            end
            default:
            begin
                if (rspValid)
                begin
                    nextState = Idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= Idle;
            credits <= credit_t'(CmdCredits); // Full pool after reset
        end
        else
        begin
            state   <= nextState;
            // Send and return in one cycle cancel out
            credits <= credits - credit_t'(sendCmd) + credit_t'(creditReturn);
        end
    end

endmodule

`default_nettype wire

/* source/controlSequencer.sv */
// Moore sequencer of the multicycle control unit
// Outputs decode the state only, except pcWrite in SFetch and SBeq
// SError is sticky until reset
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire ctrlPkg::instrClass_e instrClass,
    input  wire ctrlPkg::aluOp_t      execAluOp,
    input  wire logic                 zero,
    input  wire logic                 fetchDone,
    output logic                      fetchStart,
    output ctrlPkg::ctrlWord_t        ctrl,
    output logic                      fault
);
    import ctrlPkg::*;

    seqState_e state;
    seqState_e nextState;
    logic      fetchEntry; // First cycle of SFetch

    always_comb
    begin
        nextState = state;
        case (state)
            SFetch:
            begin
                if (fetchDone)
                begin
                    nextState = SDecode; // IR loads on this same edge
                end
            end
            SDecode:
            begin
                case (instrClass)
                    ClsLoad, ClsStore: nextState = SMemAddr;
                    ClsRType:          nextState = SExecR;
                    ClsIType:          nextState = SExecI;
                    ClsJal:            nextState = SJal;
                    ClsBranch:         nextState = SBeq;
                    default:           nextState = SError;
                endcase
            end
            SMemAddr:
            begin
                if (instrClass == ClsLoad)
                begin
                    nextState = SMemRead;
                end
                else if (instrClass == ClsStore)
                begin
                    nextState = SMemWrite;
                end
                else
                begin
                    nextState = SError; // IR changed underneath, trap
                end
            end
            SMemRead:                 nextState = SMemWb;
            SExecR, SExecI, SJal:     nextState = SAluWb;
            SMemWb, SMemWrite, SAluWb, SBeq: nextState = SFetch;
            default:                  nextState = SError; // Includes SError itself
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= SFetch;
            fetchEntry <= 1'b1; // Kick the first fetch straight away
        end
        else
        begin
            state      <= nextState;
            fetchEntry <= (nextState == SFetch) && (state != SFetch);
        end
    end

    assign fetchStart = fetchEntry;
    assign fault      = (state == SError);

    // Control word per state, unlisted fields stay zero
    always_comb
    begin
        ctrl = '0;
        case (state)
            SFetch:
            begin
                ctrl.irWrite    = 1'b1;
                ctrl.aluSrcA    = SrcAPc;       // PC + 4
                ctrl.aluSrcB    = SrcBFour;
                ctrl.aluControl = AluAdd;
                ctrl.resultSrc  = ResAluResult;
                ctrl.pcWrite    = fetchDone;    // Advance PC once the word is in
            end
            SDecode:
            begin
                ctrl.aluSrcA = SrcAOldPc;  // Branch target precompute
                ctrl.aluSrcB = SrcBImm;
            end
            SMemAddr:
            begin
                ctrl.aluSrcA = SrcAReg;
                ctrl.aluSrcB = SrcBImm;
            end
            SMemRead:
            begin
                ctrl.adrSrc = 1'b1;
            end
            SMemWb:
            begin
                ctrl.resultSrc = ResData;
                ctrl.regWrite  = 1'b1;
            end
            SMemWrite:
            begin
                ctrl.adrSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            SExecR:
            begin
                ctrl.aluSrcA    = SrcAReg;
                ctrl.aluSrcB    = SrcBReg;
                ctrl.aluControl = execAluOp;
            end
            SExecI:
            begin
                ctrl.aluSrcA    = SrcAReg;
                ctrl.aluSrcB    = SrcBImm;
                ctrl.aluControl = execAluOp;
            end
            SAluWb:
            begin
                ctrl.resultSrc = ResAluOut;
                ctrl.regWrite  = 1'b1;
            end
            SJal:
            begin
                ctrl.aluSrcA = SrcAOldPc; // Link value, target already in ALUOut
                ctrl.aluSrcB = SrcBFour;
                ctrl.pcWrite = 1'b1;
            end
            SBeq:
            begin
                ctrl.aluSrcA    = SrcAReg;
                ctrl.aluSrcB    = SrcBReg;
                ctrl.aluControl = AluSub;
                ctrl.pcWrite    = zero;     // Taken only when rs1 == rs2
            end
            default:
            begin
                ctrl = '0; // SError, datapath frozen
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/multicycleController.sv */
// Control unit of a multicycle RISC-V core, datapath is external
// rspWord is consumed by the datapath IR, not by this block
// CmdCredits must equal the bus credit pool, 1 to 7
`timescale 1ns/1ps
`default_nettype none

module multicycleController
#(
    parameter int unsigned CmdCredits = 2
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire ctrlPkg::instrFields_t instr,
    input  wire logic                  zero,
    input  wire ctrlPkg::addr_t        pc,
    input  wire logic                  creditReturn,
    input  wire logic                  rspValid,
    input  wire ctrlPkg::busWord_t     rspWord,      // Routed to the IR outside
    output ctrlPkg::busCmd_t           cmd,
    output ctrlPkg::ctrlWord_t         ctrl,
    output logic                       fault
);
    import ctrlPkg::*;

    instrClass_e instrClass;
    aluOp_t      execAluOp;
    logic        fetchStart;
    logic        fetchDone;

    opcodeDecoder decoder
    (
        .instr      (instr),
        .instrClass (instrClass),
        .execAluOp  (execAluOp)
    );

    fetchPort #(
        .CmdCredits (CmdCredits)
    ) fetcher (
        .clk          (clk),
        .reset        (reset),
        .fetchStart   (fetchStart),
        .pc           (pc),
        .creditReturn (creditReturn),
        .rspValid     (rspValid),
        .cmd          (cmd),
        .fetchDone    (fetchDone)
    );

    controlSequencer sequencer
    (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .execAluOp  (execAluOp),
        .zero       (zero),
        .fetchDone  (fetchDone),
        .fetchStart (fetchStart),
        .ctrl       (ctrl),
        .fault      (fault)
    );

endmodule

`default_nettype wire

/* bench/commandBusModel.sv */
// Command bus responder for the controller testbench
// Returns one credit per command and answers each read once, 0 to 5 idle cycles late
// hold stops credit returns, credits mirrors the controller's pool
`timescale 1ns/1ps
`default_nettype none

module commandBusModel
#(
    parameter int Credits = 2
)
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire ctrlPkg::busCmd_t  cmd,
    input  wire logic              hold,
    output logic                   creditReturn,
    output logic                   rspValid,
    output ctrlPkg::busWord_t      rspWord,
    output int                     credits
);
    import ctrlPkg::*;

    int   pendingCredits; // Consumed, not yet returned
    int   creditWait;
    int   rspWait;
    logic readPending;

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            creditReturn   <= 1'b0;
            rspValid       <= 1'b0;
            rspWord        <= '0;
            credits        <= Credits;
            pendingCredits = 0;
            creditWait     = 0;
            rspWait        = 0;
            readPending    = 1'b0;
        end
        else
        begin
            creditReturn <= 1'b0;
            rspValid     <= 1'b0;
            credits      <= credits - (cmd.valid ? 1 : 0) + (creditReturn ? 1 : 0);
            if (cmd.valid)
            begin
                pendingCredits = pendingCredits + 1;
            end
            if (!hold && pendingCredits > 0)
            begin
                if (creditWait == 0)
                begin
                    creditReturn   <= 1'b1;
                    pendingCredits = pendingCredits - 1;
                    creditWait     = int'($urandom % 6);
                end
                else
                begin
                    creditWait = creditWait - 1;
                end
            end
            if (cmd.valid && cmd.word[33:32] == CmdRead)
            begin
                readPending = 1'b1;
                rspWait     = int'($urandom % 6);
            end
            else if (readPending)
            begin
                if (rspWait == 0)
                begin
                    rspValid    <= 1'b1;
                    rspWord     <= {2'b00, 32'h0000_0013}; // Any word, IR is external
                    readPending = 1'b0;
                end
                else
                begin
                    rspWait = rspWait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/controllerTb.sv */
// Testbench of the multicycle controller with a random-delay bus model
// Rows run in order and row 1 starts with no credits left
// Outputs sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module controllerTb;
    import ctrlPkg::*;

    localparam int NumRows   = 9;
    localparam int MaxLen    = 5;
    localparam int TimeoutNs = (NumRows * 60 + 20) * 8; // 60 cycles per row

    logic         clk;
    logic         reset;
    instrFields_t instr;
    logic         zero;
    addr_t        pc;
    logic         creditReturn;
    logic         rspValid;
    busWord_t     rspWord;
    busCmd_t      cmd;
    ctrlWord_t    ctrl;
    logic         fault;
    logic         hold;
    int           modelCredits;

    // Stimulus and expected words after the fetch
    instrFields_t rowInstr [NumRows];
    logic         rowZero [NumRows];
    addr_t        rowPc [NumRows];
    int           rowLen [NumRows];
    int           rowStall [NumRows];
    logic         rowIllegal [NumRows];
    string        rowName [NumRows];
    ctrlWord_t    rowExp [NumRows][MaxLen];

    addr_t        curPc;
    int           addrCount;
    int           readCount;
    int           errors;
    int           failedTests;

    multicycleController #(
        .CmdCredits (2)
    ) i_multicycleController (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .zero         (zero),
        .pc           (pc),
        .creditReturn (creditReturn),
        .rspValid     (rspValid),
        .rspWord      (rspWord),
        .cmd          (cmd),
        .ctrl         (ctrl),
        .fault        (fault)
    );

    commandBusModel #(
        .Credits (2)
    ) busModel (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .hold         (hold),
        .creditReturn (creditReturn),
        .rspValid     (rspValid),
        .rspWord      (rspWord),
        .credits      (modelCredits)
    );

    always #4 clk = ~clk;

    function automatic ctrlWord_t mkWord(logic pcW, logic adr, logic memW, logic regW,
                                         logic [1:0] res, aluOp_t alu,
                                         logic [1:0] srcA, logic [1:0] srcB);
        ctrlWord_t w;
        w            = '0;
        w.pcWrite    = pcW;
        w.adrSrc     = adr;
        w.memWrite   = memW;
        w.regWrite   = regW;
        w.resultSrc  = res;
        w.aluControl = alu;
        w.aluSrcA    = srcA;
        w.aluSrcB    = srcB;
        return w;
    endfunction

    function automatic ctrlWord_t fetchWord(logic done);
        ctrlWord_t w;
        w         = mkWord(done, 0, 0, 0, ResAluResult, AluAdd, SrcAPc, SrcBFour);
        w.irWrite = 1'b1;
        return w;
    endfunction

    task automatic setRow(int r, string name, opcode_t op, funct3_t f3, logic f7,
                          logic z, addr_t a, int stall);
        rowName[r]     = name;
        rowInstr[r]    = '{op: op, funct3: f3, funct7b5: f7};
        rowZero[r]     = z;
        rowPc[r]       = a;
        rowStall[r]    = stall;
        rowIllegal[r]  = 1'b0;
        rowLen[r]      = 0;
    endtask

    task automatic addStep(int r, ctrlWord_t w);
        rowExp[r][rowLen[r]] = w;
        rowLen[r]            = rowLen[r] + 1;
    endtask

    task automatic fillTable();
        ctrlWord_t dec;
        ctrlWord_t aluWb;
        dec   = mkWord(0, 0, 0, 0, ResAluOut, AluAdd, SrcAOldPc, SrcBImm);
        aluWb = mkWord(0, 0, 0, 1, ResAluOut, AluAdd, SrcAPc, SrcBReg);
        setRow(0, "load", OpLoad, 3'b010, 0, 0, 32'h0000_1000, 0);
        addStep(0, dec);
        addStep(0, mkWord(0, 0, 0, 0, ResAluOut, AluAdd, SrcAReg, SrcBImm));
        addStep(0, mkWord(0, 1, 0, 0, ResAluOut, AluAdd, SrcAPc, SrcBReg));
        addStep(0, mkWord(0, 0, 0, 1, ResData, AluAdd, SrcAPc, SrcBReg));
        setRow(1, "store after stall", OpStore, 3'b010, 0, 0, 32'hC000_1004, 20);
        addStep(1, dec);
        addStep(1, mkWord(0, 0, 0, 0, ResAluOut, AluAdd, SrcAReg, SrcBImm));
        addStep(1, mkWord(0, 1, 1, 0, ResAluOut, AluAdd, SrcAPc, SrcBReg));
        setRow(2, "R add", OpRType, 3'b000, 0, 1, 32'h0000_2008, 0);
        addStep(2, dec);
        addStep(2, mkWord(0, 0, 0, 0, ResAluOut, AluRType, SrcAReg, SrcBReg));
        addStep(2, aluWb);
        setRow(3, "R sub", OpRType, 3'b000, 1, 0, 32'h3FFF_FFFC, 0);
        addStep(3, dec);
        addStep(3, mkWord(0, 0, 0, 0, ResAluOut, AluSub, SrcAReg, SrcBReg));
        addStep(3, aluWb);
        setRow(4, "I ori", OpIType, 3'b110, 1, 0, 32'h0000_0040, 0);
        addStep(4, dec);
        addStep(4, mkWord(0, 0, 0, 0, ResAluOut, 3'b110, SrcAReg, SrcBImm));
        addStep(4, aluWb);
        setRow(5, "jal", OpJal, 3'b000, 0, 0, 32'h8000_0100, 0);
        addStep(5, dec);
        addStep(5, mkWord(1, 0, 0, 0, ResAluOut, AluAdd, SrcAOldPc, SrcBFour));
        addStep(5, aluWb);
        setRow(6, "beq taken", OpBranch, 3'b000, 0, 1, 32'h0000_0200, 0);
        addStep(6, dec);
        addStep(6, mkWord(1, 0, 0, 0, ResAluOut, AluSub, SrcAReg, SrcBReg));
        setRow(7, "beq not taken", OpBranch, 3'b000, 0, 0, 32'h0000_0204, 0);
        addStep(7, dec);
        addStep(7, mkWord(0, 0, 0, 0, ResAluOut, AluSub, SrcAReg, SrcBReg));
        setRow(8, "illegal opcode", 7'b1111111, 3'b000, 0, 0, 32'h0000_0300, 0);
        addStep(8, dec);
        addStep(8, '0);
        rowIllegal[8] = 1'b1;
    endtask

    task automatic checkCtrl(ctrlWord_t got, ctrlWord_t exp, string what);
        if (got !== exp)
        begin
            $display("Error at %0t ns: %s control word %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkBusWord(busWord_t got, busWord_t exp, string what);
        if (got !== exp)
        begin
            $display("Error at %0t ns: %s command word %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkFault(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("Error at %0t ns: %s bit %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic applyRow(int r);
        instr     <= rowInstr[r];
        zero      <= rowZero[r];
        pc        <= rowPc[r];
        curPc     = rowPc[r];
        addrCount = 0;
        readCount = 0;
    endtask

    task automatic reportTest(string name, int errBefore);
        if (errors == errBefore)
        begin
            $display("Test %s: ok", name);
        end
        else
        begin
            $display("Test %s: failed", name);
            failedTests++;
        end
    endtask

    // Command monitor checks credits, payloads and order
    always @(negedge clk)
    begin
        if (!reset && cmd.valid === 1'b1)
        begin
            if (modelCredits == 0)
            begin
                $display("Command sent at %0t ns while the bus held no credit", $time);
                errors++;
            end
            if (cmd.word[33:32] == CmdSetAddr)
            begin
                checkBusWord(cmd.word, {CmdSetAddr, 2'b00, curPc[29:0]}, "address");
                addrCount++;
            end
            else
            begin
                checkBusWord(cmd.word, {CmdRead, 32'b0}, "read");
                if (addrCount == 0)
                begin
                    $display("Read command at %0t ns came before its address command", $time);
                    errors++;
                end
                readCount++;
            end
        end
    end

    initial
    begin
        #(TimeoutNs);
        $display("Timeout after %0d ns, the controller stopped making progress", TimeoutNs);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        int errBefore;
        void'($urandom(92284));
        errors       = 0;
        failedTests  = 0;
        clk          = 1'b0;
        reset        = 1'b1;
        hold         = 1'b1; // Row 0 spends both credits so row 1 stalls
        instr        = '0;
        zero         = 1'b0;
        pc           = '0;
        curPc        = '0;
        addrCount    = 0;
        readCount    = 0;
        fillTable();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        applyRow(0);
        @(negedge clk);
        errBefore = errors;
        checkFault(cmd.valid, 1'b0, "cmd.valid after reset");
        checkFault(fault, 1'b0, "fault after reset");
        checkCtrl(ctrl, fetchWord(1'b0), "first fetch");
        reportTest("reset", errBefore);
        for (int r = 0; r < NumRows; r++)
        begin
            if (r > 0)
            begin
                applyRow(r); // On the edge that enters SFetch
            end
            errBefore = errors;
            if (rowStall[r] > 0)
            begin
                repeat (rowStall[r])
                begin
                    @(negedge clk);
                    checkCtrl(ctrl, fetchWord(1'b0), "stalled fetch");
                    checkFault(cmd.valid, 1'b0, "cmd.valid without credit");
                end
                @(posedge clk);
                hold <= 1'b0;
            end
            do
            begin
                @(negedge clk);
            end
            while (!(ctrl.irWrite && ctrl.pcWrite));
            checkCtrl(ctrl, fetchWord(1'b1), "fetch end");
            for (int k = 0; k < rowLen[r]; k++)
            begin
                @(negedge clk);
                checkCtrl(ctrl, rowExp[r][k], $sformatf("%s step %0d", rowName[r], k));
                checkFault(fault, rowIllegal[r] && k == rowLen[r] - 1, "fault");
            end
            @(posedge clk);
            if (addrCount != 1 || readCount != 1)
            begin
                $display("Fetch of %s sent %0d address and %0d read commands",
                         rowName[r], addrCount, readCount);
                errors++;
            end
            if (rowIllegal[r])
            begin
                addrCount = 0;
                readCount = 0;
                repeat (10)
                begin
                    @(negedge clk);
                    checkCtrl(ctrl, '0, "error state");
                    checkFault(fault, 1'b1, "sticky fault");
                end
                if (addrCount + readCount != 0)
                begin
                    $display("Commands were sent after the error state was entered");
                    errors++;
                end
            end
            reportTest(rowName[r], errBefore);
        end
        $display("Tests %0d, failed %0d, errors %0d", NumRows + 1, failedTests, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/ctrlPkg.sv
source/opcodeDecoder.sv
source/fetchPort.sv
source/controlSequencer.sv
source/multicycleController.sv
bench/commandBusModel.sv
bench/controllerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the controller testbench with Verilator
verilator --binary --timing --top-module controllerTb -f vlog.f \
    --Mdir obj_dir -o simv > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; } || \
    grep -q "STATUS: PASS" sim.log || { echo "No result in sim.log"; exit 1; }
exit 0
